// ==== Bender.yml ====
package:
  name: drum_synth

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/drumPkg.sv
      - rtl/meshNode.sv
      - rtl/compMesh.sv
      - rtl/tensionCtrl.sv
      - rtl/stepSequencer.sv
      - rtl/drumSynth.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/drumMesh_properties.sv
      - dv/drumSynthTb.sv

// ==== drumSynth.f ====
+incdir+rtl
rtl/drumPkg.sv
rtl/meshNode.sv
rtl/compMesh.sv
rtl/tensionCtrl.sv
rtl/stepSequencer.sv
rtl/drumSynth.sv
dv/drumMesh_properties.sv
dv/drumSynthTb.sv

// ==== dv/drumMesh_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module drumMeshProps (
  input wire logic            allValid,
  input wire logic            rstN,
  input wire logic            loadInit,
  input wire logic            stepEn,
  input wire drumPkg::stereoT sample,
  input wire logic            sampleValid
);

  int failCount = 0;  // polled by the testbench at the end of each test

  // mirrored taps of a symmetric membrane always agree
  apMirror: assert property (@(posedge allValid) disable iff (!rstN)
    sampleValid |-> (sample.left == sample.right))
    else begin
      failCount++;
      $error("stereo taps differ, left %0d right %0d", sample.left, sample.right);
    end

  // every mesh update is reported two edges later
  apValidFollows: assert property (@(posedge allValid) disable iff (!rstN)
    (loadInit || stepEn) |-> ##2 sampleValid)
    else begin
      failCount++;
      $error("mesh update without a sampleValid pulse");
    end

  // and no pulse without an update behind it
  apValidCause: assert property (@(posedge allValid) disable iff (!rstN)
    sampleValid |-> $past(loadInit || stepEn, 2))
    else begin
      failCount++;
      $error("sampleValid pulse without a mesh update");
    end

endmodule

bind drumSynth drumMeshProps uProps (
  .allValid    (allValid),
  .rstN        (rstN),
  .loadInit    (loadInit),
  .stepEn      (stepEn),
  .sample      (sample),
  .sampleValid (sampleValid)
);

`default_nettype wire

// ==== dv/drumSynthTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "drumMesh_consts.svh"

module drumSynthTb;

  // cycle budget per test, worst case
  localparam int resetLen  = 8;
  localparam int quietLen  = 24;
  localparam int settleLen = 3;
  localparam int strikeLen = 6;
  localparam int maxRun    = 60;
  localparam int dropLen   = 14;
  localparam int rounds    = 4;   // random strikes in test 3
  localparam int constRun  = 40;
  localparam int roundLen  = settleLen + 1 + strikeLen + maxRun + dropLen;
  localparam int testSum   = resetLen + quietLen + roundLen * (rounds + 3)
                             + strikeLen + 10;
  localparam int cycleLimit = testSum * 3 / 2;

  logic              allValid;
  logic              rstN;
  drumPkg::drumCtrlT ctrl;
  logic              strike;
  logic              run;
  drumPkg::stereoT   sample;
  logic              sampleValid;

  logic [31:0]     rngState = 32'd32409;
  int              errCount = 0;
  int              testsFailed = 0;
  int              cycleCount = 0;
  drumPkg::sampleT tapInitL;   // expected bell value at the left tap
  drumPkg::sampleT tapInitR;

  drumSynth i_drumSynth (
    .allValid    (allValid),
    .rstN        (rstN),
    .ctrl        (ctrl),
    .strike      (strike),
    .run         (run),
    .sample      (sample),
    .sampleValid (sampleValid)
  );

  initial allValid = 1'b0;
  always #2 allValid = ~allValid;  // 4 ns period

  always @(posedge allValid) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // bell value of a node, distance in whole nodes from the grid midpoint
  function automatic int bellValue(input int col, input int row);
    int ox;  // offsets in half-node units
    int oy;
    int sq;
    int d;
    ox = 2 * col - (`MESH_X - 1);
    oy = 2 * row - (`MESH_Y - 1);
    sq = ox * ox + oy * oy;
    d  = 0;
    while (4 * (d + 1) * (d + 1) <= sq) d++;  // largest d with d*d <= sq/4
    if (d >= 15) return 0;
    return -(`PLUCK_PEAK / (1 << d));
  endfunction

  function automatic int totalErrors();
    return errCount + i_drumSynth.uProps.failCount;  // bound checks count too
  endfunction

  task automatic checkValue(input string name, input drumPkg::sampleT got,
                            input drumPkg::sampleT exp);
    assert (got == exp) else begin
      errCount++;
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, got);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      errCount++;
      $display("ERROR at %0t: %s expected %0b, got %0b", $time, name, exp, got);
    end
  endtask

  task automatic endTest(input int num, input string name, input int errStart);
    int errs;
    errs = totalErrors() - errStart;
    if (errs == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      testsFailed++;
      $display("test %0d %s: %0d errors", num, name, errs);
    end
  endtask

  task automatic applyCtrl(input int rho, input int eta, input int sel);
    @(posedge allValid);
    ctrl.rho        <= drumPkg::sampleT'(rho);
    ctrl.eta        <= drumPkg::sampleT'(eta);
    ctrl.tensionSel <= 3'(sel);
    run             <= 1'b1;
    repeat (settleLen) @(posedge allValid);  // rhoEff is registered
  endtask

  task automatic randomCtrl();
    int rho;
    int eta;
    rngState = xorshift(rngState);
    rho      = rngState % `RHO_MAX;  // stays below the clamp
    rngState = xorshift(rngState);
    eta      = rngState % 4096;      // light damping
    rngState = xorshift(rngState);
    applyCtrl(rho, eta, rngState % 8);
  endtask

  // strike pulse, first fresh sample lands 3 edges after the strike edge
  task automatic strikeCheck(input logic fromIdle);
    @(posedge allValid);
    strike <= 1'b1;
    @(posedge allValid);
    strike <= 1'b0;
    for (int k = 0; k < 3; k++) begin
      @(negedge allValid);
      if (fromIdle) checkFlag("sampleValid", sampleValid, 1'b0);
    end
    @(negedge allValid);
    checkFlag("sampleValid", sampleValid, 1'b1);
    checkValue("sample.left", sample.left, tapInitL);
    checkValue("sample.right", sample.right, tapInitR);
  endtask

  task automatic runCycles(input int n, input logic expectConst);
    for (int k = 0; k < n; k++) begin
      @(negedge allValid);
      if (expectConst && sampleValid) begin
        checkValue("sample.left", sample.left, tapInitL);
        checkValue("sample.right", sample.right, tapInitR);
      end
    end
  endtask

  task automatic randomRun();
    rngState = xorshift(rngState);
    runCycles(20 + rngState % 41, 1'b0);
  endtask

  // last step still reported one cycle after the drop edge, then silence
  task automatic dropRun();
    @(posedge allValid);
    run <= 1'b0;
    @(posedge allValid);
    @(negedge allValid);
    @(negedge allValid);
    checkFlag("sampleValid", sampleValid, 1'b1);
    repeat (10) begin
      @(negedge allValid);
      checkFlag("sampleValid", sampleValid, 1'b0);
    end
  endtask

  initial begin
    int errStart;
    rstN   <= 1'b0;
    ctrl   <= '0;
    strike <= 1'b0;
    run    <= 1'b0;
    tapInitL = drumPkg::sampleT'(bellValue(`TAP_X, `TAP_Y));
    tapInitR = drumPkg::sampleT'(bellValue(`MESH_X - 1 - `TAP_X, `TAP_Y));
    repeat (resetLen) @(posedge allValid);
    rstN <= 1'b1;

    errStart = totalErrors();
    for (int k = 0; k < quietLen; k++) begin
      @(negedge allValid);
      checkFlag("sampleValid", sampleValid, 1'b0);
      checkValue("sample.left", sample.left, '0);
      checkValue("sample.right", sample.right, '0);
    end
    endTest(1, "quiet after reset", errStart);

    errStart = totalErrors();
    randomCtrl();
    strikeCheck(1'b1);
    randomRun();
    dropRun();
    endTest(2, "first sample after strike", errStart);

    errStart = totalErrors();
    for (int i = 0; i < rounds; i++) begin
      randomCtrl();
      strikeCheck(1'b1);
      randomRun();
      dropRun();
    end
    endTest(3, "stereo symmetry", errStart);

    errStart = totalErrors();
    rngState = xorshift(rngState);
    applyCtrl(0, rngState % 4096, 0);  // no tension, membrane frozen
    strikeCheck(1'b1);
    runCycles(constRun, 1'b1);
    dropRun();
    endTest(4, "frozen membrane", errStart);

    errStart = totalErrors();
    randomCtrl();
    strikeCheck(1'b1);
    runCycles(30, 1'b0);
    strikeCheck(1'b0);  // restrike while running
    runCycles(10, 1'b0);
    dropRun();
    endTest(5, "restrike and stop", errStart);

    $display("tests 5, failed %0d, errors %0d", testsFailed, totalErrors());
    if (testsFailed == 0 && totalErrors() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/compMesh.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "drumMesh_consts.svh"

module compMesh (
  input  wire logic            allValid,
  input  wire logic            rstN,
  input  wire logic            loadInit,
  input  wire logic            stepEn,
  input  wire drumPkg::sampleT rhoEff,
  input  wire drumPkg::sampleT eta,
  output drumPkg::sampleT      centreU,  // amplitude for the tension block
  output drumPkg::stereoT      taps
);

  // integer square root, elaboration only
  function automatic int isqrt(input int n);
    int r;
    r = 0;
    for (int i = 1; i < 64; i++) begin
      if (i * i <= n) r = i;
    end
    return r;
  endfunction

  // bell shape, halves per unit distance from the geometric centre
  function automatic drumPkg::sampleT initValue(input int x, input int y);
    int dx2;  // doubled offsets keep the half-node centre exact
    int dy2;
    int d;
    dx2 = 2 * x - (`MESH_X - 1);
    dy2 = 2 * y - (`MESH_Y - 1);
    d   = isqrt((dx2 * dx2 + dy2 * dy2) / 4);
    if (d >= 15) return '0;
    return drumPkg::sampleT'(-(`PLUCK_PEAK >>> d));
  endfunction

  drumPkg::sampleT meshU [`MESH_Y][`MESH_X]; // node displacements, [row][col]

  for (genvar y = 0; y < `MESH_Y; y++) begin : gRow
    for (genvar x = 0; x < `MESH_X; x++) begin : gCol
      localparam drumPkg::sampleT uInit = initValue(x, y);

      drumPkg::sampleT uNorth;
      drumPkg::sampleT uSouth;
      drumPkg::sampleT uEast;
      drumPkg::sampleT uWest;

      // fixed zero boundary outside the grid
      if (y > 0) begin : gN
        assign uNorth = meshU[y-1][x];
      end else begin : gNEdge
        assign uNorth = '0;
      end
      if (y < `MESH_Y - 1) begin : gS
        assign uSouth = meshU[y+1][x];
      end else begin : gSEdge
        assign uSouth = '0;
      end
      if (x < `MESH_X - 1) begin : gE
        assign uEast = meshU[y][x+1];
      end else begin : gEEdge
        assign uEast = '0;
      end
      if (x > 0) begin : gW
        assign uWest = meshU[y][x-1];
      end else begin : gWEdge
        assign uWest = '0;
      end

      meshNode uNode (
        .allValid (allValid),
        .rstN     (rstN),
        .loadInit (loadInit),
        .stepEn   (stepEn),
        .uInit    (uInit),
        .uNorth   (uNorth),
        .uSouth   (uSouth),
        .uEast    (uEast),
        .uWest    (uWest),
        .rhoEff   (rhoEff),
        .eta      (eta),
        .u        (meshU[y][x])
      );
    end
  end

  assign centreU    = meshU[`MESH_Y/2][`MESH_X/2];
  assign taps.left  = meshU[`TAP_Y][`TAP_X];
  assign taps.right = meshU[`TAP_Y][`MESH_X-1-`TAP_X]; // mirror column

endmodule

`default_nettype wire

// ==== rtl/drumMesh_consts.svh ====
`ifndef DRUMMESH_CONSTS_SVH
`define DRUMMESH_CONSTS_SVH

// membrane grid size in nodes
`define MESH_X 8
`define MESH_Y 8

// displacement format, signed with 17 fraction bits
`define SAMPLE_W 18
`define FRAC_W 17

`define PLUCK_PEAK 32768   // 0.25 in fixed point
`define RHO_MAX 65535      // just under 0.5, explicit scheme limit

// left listening tap, right tap mirrors the column
`define TAP_X 2
`define TAP_Y 3

`endif

// ==== rtl/drumPkg.sv ====
`default_nettype none

`include "drumMesh_consts.svh"

package drumPkg;

  // node displacement
  typedef logic signed [`SAMPLE_W-1:0] sampleT;

  // drum parameters, held as levels at the top
  typedef struct packed {
    sampleT     rho;        // base wave coefficient
    sampleT     eta;        // damping
    logic [2:0] tensionSel; // 0 disables the pitch glide
  } drumCtrlT;

  // stereo tap pair
  typedef struct packed {
    sampleT left;
    sampleT right;
  } stereoT;

  typedef enum logic [1:0] {
    idle,
    pluck,
    run
  } seqStateT;

endpackage

`default_nettype wire

// ==== rtl/drumSynth.sv ====
`timescale 1ns/100ps
`default_nettype none

module drumSynth (
  input  wire logic              allValid,
  input  wire logic              rstN,
  input  wire drumPkg::drumCtrlT ctrl,
  input  wire logic              strike,
  input  wire logic              run,
  output drumPkg::stereoT        sample,
  output logic                   sampleValid
);

  logic            loadInit;
  logic            stepEn;
  drumPkg::sampleT centreU;  // mesh to tension
  drumPkg::sampleT rhoEff;   // tension to mesh
  drumPkg::stereoT taps;

  stepSequencer uSeq (
    .allValid    (allValid),
    .rstN        (rstN),
    .strike      (strike),
    .run         (run),
    .taps        (taps),
    .loadInit    (loadInit),
    .stepEn      (stepEn),
    .sample      (sample),
    .sampleValid (sampleValid)
  );

  tensionCtrl uTension (
    .allValid (allValid),
    .rstN     (rstN),
    .ctrl     (ctrl),
    .centreU  (centreU),
    .rhoEff   (rhoEff)
  );

  compMesh uMesh (
    .allValid (allValid),
    .rstN     (rstN),
    .loadInit (loadInit),
    .stepEn   (stepEn),
    .rhoEff   (rhoEff),
    .eta      (ctrl.eta),  // damping goes straight to the nodes
    .centreU  (centreU),
    .taps     (taps)
  );

endmodule

`default_nettype wire

// ==== rtl/meshNode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "drumMesh_consts.svh"

module meshNode (
  input  wire logic            allValid,
  input  wire logic            rstN,
  input  wire logic            loadInit,  // take uInit into u and uPrev
  input  wire logic            stepEn,    // advance one time step
  input  wire drumPkg::sampleT uInit,
  input  wire drumPkg::sampleT uNorth,
  input  wire drumPkg::sampleT uSouth,
  input  wire drumPkg::sampleT uEast,
  input  wire drumPkg::sampleT uWest,
  input  wire drumPkg::sampleT rhoEff,
  input  wire drumPkg::sampleT eta,
  output drumPkg::sampleT      u
);

  localparam int W  = `SAMPLE_W;
  localparam int PW = 2 * `SAMPLE_W + 4; // room for both products

  // saturation bounds of the sample range
  localparam logic signed [PW-1:0] maxVal = PW'((64'sd1 <<< (W - 1)) - 64'sd1);
  localparam logic signed [PW-1:0] minVal = -maxVal - PW'(1);

  drumPkg::sampleT      uPrev;    // displacement one step back
  drumPkg::sampleT      uNext;
  logic signed [W:0]    vel;      // u - uPrev
  logic signed [W+2:0]  lap;      // discrete laplacian, 4 neighbours
  logic signed [PW-1:0] dampProd;
  logic signed [PW-1:0] tensProd;
  logic signed [PW-1:0] nextWide; // unsaturated next value

  always_comb begin
    vel      = u - uPrev;
    lap      = uNorth + uSouth + uEast + uWest - (u <<< 2);
    dampProd = eta * vel;    // velocity loss
    tensProd = rhoEff * lap; // restoring force
    // leapfrog step, products rescaled to the sample format
    nextWide = u + vel - (dampProd >>> `FRAC_W) + (tensProd >>> `FRAC_W);
    if (nextWide > maxVal) begin
      uNext = drumPkg::sampleT'(maxVal); // clip high
    end else if (nextWide < minVal) begin
      uNext = drumPkg::sampleT'(minVal); // clip low
    end else begin
      uNext = drumPkg::sampleT'(nextWide);
    end
  end

  always_ff @(posedge allValid) begin
    if (!rstN) begin
      u     <= '0;
      uPrev <= '0;
    end else if (loadInit) begin
      // at rest, zero velocity
      u     <= uInit;
      uPrev <= uInit;
    end else if (stepEn) begin
      u     <= uNext;
      uPrev <= u;  // old u becomes history
    end
  end

endmodule

`default_nettype wire

// ==== rtl/stepSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module stepSequencer (
  input  wire logic            allValid,
  input  wire logic            rstN,
  input  wire logic            strike,      // one cycle pulse
  input  wire logic            run,         // level
  input  wire drumPkg::stereoT taps,
  output logic                 loadInit,
  output logic                 stepEn,
  output drumPkg::stereoT      sample,
  output logic                 sampleValid
);

  drumPkg::seqStateT state;
  drumPkg::seqStateT stateNext;
  logic              stepped;  // mesh changed last cycle

  always_comb begin
    stateNext = state;
    case (state)
      drumPkg::idle:  if (strike) stateNext = drumPkg::pluck;
      drumPkg::pluck: stateNext = run ? drumPkg::run : drumPkg::idle;
      drumPkg::run: begin
        if (strike) begin
          stateNext = drumPkg::pluck;  // restart the membrane
        end else if (!run) begin
          stateNext = drumPkg::idle;
        end
      end
      default: stateNext = drumPkg::idle;
    endcase
  end

  always_ff @(posedge allValid) begin
    if (!rstN) begin
      state       <= drumPkg::idle;
      loadInit    <= 1'b0;
      stepEn      <= 1'b0;
      stepped     <= 1'b0;
      sampleValid <= 1'b0;
      sample      <= '0;
    end else begin
      state    <= stateNext;
      loadInit <= (state == drumPkg::pluck);  // exactly one cycle per pluck
      // steps only once the load is done, stop at once on drop or restrike
      stepEn   <= (state == drumPkg::run) && (stateNext == drumPkg::run);
      stepped  <= loadInit | stepEn;
      sampleValid <= stepped;
      if (stepped) begin
        sample <= taps;  // taps settled one edge after the mesh update
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tensionCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "drumMesh_consts.svh"

module tensionCtrl (
  input  wire logic             allValid,
  input  wire logic             rstN,
  input  wire drumPkg::drumCtrlT ctrl,
  input  wire drumPkg::sampleT  centreU,
  output drumPkg::sampleT       rhoEff   // registered, clamped coefficient
);

  localparam int W = `SAMPLE_W;

  logic signed [W:0]   absU;     // one extra bit, -min fits
  logic [3:0]          shiftAmt;
  logic signed [W:0]   boost;    // amplitude dependent raise
  logic signed [W+1:0] rhoSum;

  always_comb begin
    absU     = centreU[W-1] ? -centreU : centreU;
    shiftAmt = 4'd9 - {1'b0, ctrl.tensionSel}; // sel 1..7 gives 8..2
    if (ctrl.tensionSel == 3'd0) begin
      boost = '0;  // glide off
    end else begin
      boost = absU >>> shiftAmt;
    end
    rhoSum = ctrl.rho + boost;
  end

  always_ff @(posedge allValid) begin
    if (!rstN) begin
      rhoEff <= '0;
    end else if (rhoSum > `RHO_MAX) begin
      // keep the explicit update stable
      rhoEff <= drumPkg::sampleT'(`RHO_MAX);
    end else begin
      rhoEff <= drumPkg::sampleT'(rhoSum);
    end
  end

endmodule

`default_nettype wire
